// ==== hw/isa_pkg.sv ====
package isa_pkg;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SB      = 6'h28,
		OP_SW      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23
	} funct_e;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_LUI
	} alu_op_e;

	// low bit of each instruction field
	localparam int OP_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

	// where an operand is taken from
	typedef enum logic [1:0] {
		FWD_RF,
		FWD_M,
		FWD_W
	} fwd_sel_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PC8
	} wb_sel_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_WORD,
		MEM_BYTE
	} mem_type_e;

	function automatic logic [31:0] fwd_pick(input fwd_sel_e sel, input logic [31:0] rf_val,
		input logic [31:0] m_val, input logic [31:0] w_val);
		case (sel)
			FWD_M:   return m_val;
			FWD_W:   return w_val;
			default: return rf_val;
		endcase
	endfunction

endpackage

// ==== hw/fetch.sv ====
`timescale 1ns/1ps

module fetch #(
	parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        stall,
	input  logic        branch_taken,
	input  logic        jump,
	input  logic [31:0] target,
	input  logic [31:0] inst_rdata,
	output logic [31:0] pc_f,
	output logic [31:0] inst_d,
	output logic [31:0] pc_d
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_f   <= RESET_PC;
			inst_d <= 32'd0; // sll $0 acts as nop
			pc_d   <= RESET_PC;
		end else if (!stall) begin
			pc_f   <= (branch_taken || jump) ? target : pc_f + 32'd4;
			inst_d <= inst_rdata;
			pc_d   <= pc_f;
		end
	end

	a_pc_align: assert property (@(posedge clk) disable iff (!arst_n)
		pc_f[1:0] == 2'b00);

endmodule

// ==== hw/decode.sv ====
`timescale 1ns/1ps

module decode (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                flush,
	input  logic [31:0]         inst_d,
	input  logic [31:0]         pc_d,
	input  pipe_pkg::fwd_sel_e  fwd_a,
	input  pipe_pkg::fwd_sel_e  fwd_b,
	input  logic [31:0]         res_m,
	input  logic [31:0]         res_w,
	input  logic                we_w,
	input  logic [4:0]          waddr_w,
	output logic                branch_taken,
	output logic                jump,
	output logic [31:0]         target,
	output logic [4:0]          rs_d,
	output logic [4:0]          rt_d,
	output logic [1:0]          tuse_rs,
	output logic [1:0]          tuse_rt,
	output isa_pkg::alu_op_e    aluop_e,
	output pipe_pkg::wb_sel_e   wbsel_e,
	output pipe_pkg::mem_type_e memtype_e,
	output logic [4:0]          waddr_e,
	output logic [1:0]          tnew_e,
	output logic [4:0]          rs_e,
	output logic [4:0]          rt_e,
	output logic [31:0]         op_a_e,
	output logic [31:0]         op_b_e,
	output logic [31:0]         imm_e,
	output logic [31:0]         pc8_e
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e     op;
	funct_e      funct;
	logic [4:0]  rd;
	logic [31:0] rf [32];
	logic [31:0] rd_a, rd_b;
	logic [31:0] val_a, val_b;
	logic [31:0] ext_imm;
	alu_op_e     alu_op;
	wb_sel_e     wb_sel;
	mem_type_e   mem_type;
	logic [4:0]  waddr;
	logic [1:0]  tnew;
	logic        is_beq, is_jal, is_jr;

	assign op    = opcode_e'(inst_d[OP_LSB +: 6]);
	assign funct = funct_e'(inst_d[5:0]);
	assign rs_d  = inst_d[RS_LSB +: 5];
	assign rt_d  = inst_d[RT_LSB +: 5];
	assign rd    = inst_d[RD_LSB +: 5];

	always_ff @(posedge clk) begin
		if (we_w && waddr_w != 5'd0)
			rf[waddr_w] <= res_w;
	end

	// write-through so a same-cycle writeback is seen
	assign rd_a = (rs_d == 5'd0) ? 32'd0 : (we_w && waddr_w == rs_d) ? res_w : rf[rs_d];
	assign rd_b = (rt_d == 5'd0) ? 32'd0 : (we_w && waddr_w == rt_d) ? res_w : rf[rt_d];
	assign val_a = fwd_pick(fwd_a, rd_a, res_m, res_w);
	assign val_b = fwd_pick(fwd_b, rd_b, res_m, res_w);

	always_comb begin
		alu_op   = ALU_ADD;
		wb_sel   = WB_ALU;
		mem_type = MEM_NONE;
		waddr    = 5'd0;  // 0 means no register write
		tnew     = 2'd0;
		tuse_rs  = 2'd3;  // 3 = not read
		tuse_rt  = 2'd3;
		is_beq   = 1'b0;
		is_jal   = 1'b0;
		is_jr    = 1'b0;
		case (op)
			OP_SPECIAL: begin
				if (funct == F_ADDU || funct == F_SUBU) begin
					alu_op  = (funct == F_SUBU) ? ALU_SUB : ALU_ADD;
					waddr   = rd;
					tnew    = 2'd1;
					tuse_rs = 2'd1;
					tuse_rt = 2'd1;
				end else if (funct == F_JR) begin
					is_jr   = 1'b1;
					tuse_rs = 2'd0;
				end
			end
			OP_ORI, OP_LUI: begin
				alu_op  = (op == OP_ORI) ? ALU_OR : ALU_LUI;
				waddr   = rt_d;
				tnew    = 2'd1;
				tuse_rs = (op == OP_ORI) ? 2'd1 : 2'd3;
			end
			OP_LW: begin
				wb_sel   = WB_LOAD;
				mem_type = MEM_WORD;
				waddr    = rt_d;
				tnew     = 2'd2;
				tuse_rs  = 2'd1;
			end
			OP_SW, OP_SB: begin
				mem_type = (op == OP_SB) ? MEM_BYTE : MEM_WORD;
				tuse_rs  = 2'd1;
				tuse_rt  = 2'd2; // store data needed only in M
			end
			OP_BEQ: begin
				is_beq  = 1'b1;
				tuse_rs = 2'd0;
				tuse_rt = 2'd0;
			end
			OP_JAL: begin
				is_jal = 1'b1;
				wb_sel = WB_PC8;
				waddr  = 5'd31;
				tnew   = 2'd1; // pc+8 forwardable from M
			end
			default: ;
		endcase
	end

	assign ext_imm = (op == OP_ORI || op == OP_LUI) ? {16'd0, inst_d[15:0]} :
		{{16{inst_d[15]}}, inst_d[15:0]};

	assign branch_taken = is_beq && (val_a == val_b);
	assign jump         = is_jal || is_jr;

	always_comb begin
		if (is_jr)
			target = val_a;
		else if (is_jal)
			target = {pc_d[31:28], inst_d[25:0], 2'b00};
		else
			target = pc_d + 32'd4 + {ext_imm[29:0], 2'b00};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aluop_e   <= ALU_ADD;
			wbsel_e   <= WB_ALU;
			memtype_e <= MEM_NONE;
			waddr_e   <= 5'd0;
			tnew_e    <= 2'd0;
			rs_e      <= 5'd0;
			rt_e      <= 5'd0;
		end else begin
			aluop_e   <= alu_op;
			wbsel_e   <= wb_sel;
			memtype_e <= flush ? MEM_NONE : mem_type; // bubble on flush
			waddr_e   <= flush ? 5'd0 : waddr;
			tnew_e    <= flush ? 2'd0 : tnew;
			rs_e      <= rs_d;
			rt_e      <= rt_d;
		end
	end

	always_ff @(posedge clk) begin
		op_a_e <= val_a;
		op_b_e <= val_b;
		imm_e  <= ext_imm;
		pc8_e  <= pc_d + 32'd8;
	end

	// jr lands on a word boundary once its operand is final
	a_jr_align: assert property (@(posedge clk) disable iff (!arst_n)
		(is_jr && !flush) |-> val_a[1:0] == 2'b00);

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/1ps

module execute (
	input  logic                clk,
	input  logic                arst_n,
	input  pipe_pkg::fwd_sel_e  fwd_a,
	input  pipe_pkg::fwd_sel_e  fwd_b,
	input  logic [31:0]         res_m,
	input  logic [31:0]         res_w,
	input  isa_pkg::alu_op_e    aluop_e,
	input  pipe_pkg::wb_sel_e   wbsel_e,
	input  pipe_pkg::mem_type_e memtype_e,
	input  logic [4:0]          waddr_e,
	input  logic [1:0]          tnew_e,
	input  logic [4:0]          rt_e,
	input  logic [31:0]         op_a_e,
	input  logic [31:0]         op_b_e,
	input  logic [31:0]         imm_e,
	input  logic [31:0]         pc8_e,
	output logic [31:0]         alu_res_m,
	output logic [31:0]         store_data_m,
	output logic [31:0]         pc8_m,
	output logic [4:0]          waddr_m,
	output logic [1:0]          tnew_m,
	output logic [4:0]          rt_m,
	output pipe_pkg::wb_sel_e   wb_sel_m,
	output pipe_pkg::mem_type_e mem_type_m,
	output logic [4:0]          waddr_x,
	output logic [1:0]          tnew_x
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [31:0] src_a, rt_val, src_b, alu_res;
	logic        use_imm;

	assign src_a  = fwd_pick(fwd_a, op_a_e, res_m, res_w);
	assign rt_val = fwd_pick(fwd_b, op_b_e, res_m, res_w);

	// only addu/subu take rt as the second operand
	assign use_imm = memtype_e != MEM_NONE || aluop_e == ALU_OR || aluop_e == ALU_LUI;
	assign src_b   = use_imm ? imm_e : rt_val;

	always_comb begin
		case (aluop_e)
			ALU_SUB: alu_res = src_a - src_b;
			ALU_OR:  alu_res = src_a | src_b;
			ALU_LUI: alu_res = {src_b[15:0], 16'd0};
			default: alu_res = src_a + src_b;
		endcase
	end

	assign waddr_x = waddr_e;
	assign tnew_x  = tnew_e;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			waddr_m    <= 5'd0;
			tnew_m     <= 2'd0;
			rt_m       <= 5'd0;
			wb_sel_m   <= WB_ALU;
			mem_type_m <= MEM_NONE;
		end else begin
			waddr_m    <= waddr_e;
			tnew_m     <= (tnew_e == 2'd0) ? 2'd0 : tnew_e - 2'd1;
			rt_m       <= rt_e;
			wb_sel_m   <= wbsel_e;
			mem_type_m <= memtype_e;
		end
	end

	always_ff @(posedge clk) begin
		alu_res_m    <= alu_res;
		store_data_m <= rt_val; // may still be stale after a load, fixed in M
		pc8_m        <= pc8_e;
	end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  pipe_pkg::fwd_sel_e  fwd_st,
	input  logic [31:0]         alu_res_m,
	input  logic [31:0]         store_data_m,
	input  logic [31:0]         pc8_m,
	input  logic [4:0]          waddr_m,
	input  pipe_pkg::wb_sel_e   wb_sel_m,
	input  pipe_pkg::mem_type_e mem_type_m,
	input  logic [31:0]         data_rdata,
	output logic [31:0]         data_addr,
	output logic [31:0]         data_wdata,
	output logic [3:0]          byteen,
	output logic [31:0]         inst_addr_m,
	output logic [31:0]         res_m,
	output logic                we_w,
	output logic [4:0]          waddr_w,
	output logic [31:0]         res_w,
	output logic [31:0]         pc_w
);
	import pipe_pkg::*;

	logic [31:0] st_data;
	logic        is_store;
	wb_sel_e     wb_sel_w;
	logic [31:0] res_m_w, load_w;

	assign data_addr   = alu_res_m;
	assign inst_addr_m = pc8_m - 32'd8;
	assign res_m       = (wb_sel_m == WB_PC8) ? pc8_m : alu_res_m;
	assign st_data     = fwd_pick(fwd_st, store_data_m, res_m, res_w);
	assign is_store    = mem_type_m != MEM_NONE && wb_sel_m != WB_LOAD;

	always_comb begin
		data_wdata = st_data;
		byteen     = 4'b0000;
		if (is_store) begin
			if (mem_type_m == MEM_BYTE) begin
				data_wdata = {24'd0, st_data[7:0]} << {alu_res_m[1:0], 3'b000};
				byteen     = 4'b0001 << alu_res_m[1:0];
			end else begin
				byteen = 4'b1111;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			we_w     <= 1'b0;
			waddr_w  <= 5'd0;
			wb_sel_w <= WB_ALU;
		end else begin
			we_w     <= waddr_m != 5'd0; // $0 writes dropped here
			waddr_w  <= waddr_m;
			wb_sel_w <= wb_sel_m;
		end
	end

	always_ff @(posedge clk) begin
		res_m_w <= res_m;
		load_w  <= data_rdata; // lw only, whole word
		pc_w    <= inst_addr_m;
	end

	assign res_w = (wb_sel_w == WB_LOAD) ? load_w : res_m_w;

	// word loads and stores need an aligned address
	a_word_align: assert property (@(posedge clk) disable iff (!arst_n)
		mem_type_m == MEM_WORD |-> data_addr[1:0] == 2'b00);

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  logic               [4:0] rs_d,
	input  logic               [4:0] rt_d,
	input  logic               [1:0] tuse_rs,
	input  logic               [1:0] tuse_rt,
	input  logic               [4:0] waddr_x,
	input  logic               [1:0] tnew_x,
	input  logic               [4:0] rs_e,
	input  logic               [4:0] rt_e,
	input  logic               [4:0] waddr_m,
	input  logic               [1:0] tnew_m,
	input  logic               [4:0] rt_m,
	input  logic                     we_w,
	input  logic               [4:0] waddr_w,
	output logic                     stall,
	output logic                     flush,
	output pipe_pkg::fwd_sel_e       fwd_cmp_a,
	output pipe_pkg::fwd_sel_e       fwd_cmp_b,
	output pipe_pkg::fwd_sel_e       fwd_alu_a,
	output pipe_pkg::fwd_sel_e       fwd_alu_b,
	output pipe_pkg::fwd_sel_e       fwd_st
);
	import pipe_pkg::*;

	// producer in E or M not ready before the reader needs it
	function automatic logic late(input logic [4:0] src, input logic [1:0] tuse);
		if (src == 5'd0)
			return 1'b0;
		return (src == waddr_x && tnew_x > tuse) || (src == waddr_m && tnew_m > tuse);
	endfunction

	// newest ready producer wins, E results never forward
	function automatic fwd_sel_e pick(input logic [4:0] src, input logic use_m);
		if (src == 5'd0)
			return FWD_RF;
		if (use_m && src == waddr_m && tnew_m == 2'd0)
			return FWD_M;
		if (we_w && src == waddr_w)
			return FWD_W;
		return FWD_RF;
	endfunction

	always_comb begin
		stall     = late(rs_d, tuse_rs) || late(rt_d, tuse_rt);
		flush     = stall; // bubble into E while F/D hold
		fwd_cmp_a = pick(rs_d, 1'b1);
		fwd_cmp_b = pick(rt_d, 1'b1);
		fwd_alu_a = pick(rs_e, 1'b1);
		fwd_alu_b = pick(rt_e, 1'b1);
		fwd_st    = pick(rt_m, 1'b0); // only W is newer than M
	end

endmodule

// ==== hw/mips.sv ====
`timescale 1ns/1ps

module mips #(
	parameter logic [31:0] RESET_PC = 32'h0000_3000
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] i_inst_rdata,
	input  logic [31:0] m_data_rdata,
	output logic [31:0] i_inst_addr,
	output logic [31:0] m_data_addr,
	output logic [31:0] m_data_wdata,
	output logic [3:0]  m_data_byteen,
	output logic [31:0] m_inst_addr,
	output logic        w_grf_we,
	output logic [4:0]  w_grf_addr,
	output logic [31:0] w_grf_wdata,
	output logic [31:0] w_inst_addr
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic        stall, flush, branch_taken, jump;
	logic [31:0] target, inst_d, pc_d, res_m;
	fwd_sel_e    fwd_cmp_a, fwd_cmp_b, fwd_alu_a, fwd_alu_b, fwd_st;
	logic [4:0]  rs_d, rt_d, rs_e, rt_e, waddr_e, waddr_m, rt_m, waddr_x;
	logic [1:0]  tuse_rs, tuse_rt, tnew_e, tnew_m, tnew_x;
	alu_op_e     aluop_e;
	wb_sel_e     wbsel_e, wb_sel_m;
	mem_type_e   memtype_e, mem_type_m;
	logic [31:0] op_a_e, op_b_e, imm_e, pc8_e;
	logic [31:0] alu_res_m, store_data_m, pc8_m;

	fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .arst_n(arst_n), .stall(stall),
		.branch_taken(branch_taken), .jump(jump), .target(target),
		.inst_rdata(i_inst_rdata), .pc_f(i_inst_addr), .inst_d(inst_d), .pc_d(pc_d)
	);

	decode u_decode (
		.clk(clk), .arst_n(arst_n), .flush(flush), .inst_d(inst_d), .pc_d(pc_d),
		.fwd_a(fwd_cmp_a), .fwd_b(fwd_cmp_b), .res_m(res_m), .res_w(w_grf_wdata),
		.we_w(w_grf_we), .waddr_w(w_grf_addr),
		.branch_taken(branch_taken), .jump(jump), .target(target),
		.rs_d(rs_d), .rt_d(rt_d), .tuse_rs(tuse_rs), .tuse_rt(tuse_rt),
		.aluop_e(aluop_e), .wbsel_e(wbsel_e), .memtype_e(memtype_e),
		.waddr_e(waddr_e), .tnew_e(tnew_e), .rs_e(rs_e), .rt_e(rt_e),
		.op_a_e(op_a_e), .op_b_e(op_b_e), .imm_e(imm_e), .pc8_e(pc8_e)
	);

	execute u_execute (
		.clk(clk), .arst_n(arst_n), .fwd_a(fwd_alu_a), .fwd_b(fwd_alu_b),
		.res_m(res_m), .res_w(w_grf_wdata),
		.aluop_e(aluop_e), .wbsel_e(wbsel_e), .memtype_e(memtype_e),
		.waddr_e(waddr_e), .tnew_e(tnew_e), .rt_e(rt_e),
		.op_a_e(op_a_e), .op_b_e(op_b_e), .imm_e(imm_e), .pc8_e(pc8_e),
		.alu_res_m(alu_res_m), .store_data_m(store_data_m), .pc8_m(pc8_m),
		.waddr_m(waddr_m), .tnew_m(tnew_m), .rt_m(rt_m),
		.wb_sel_m(wb_sel_m), .mem_type_m(mem_type_m),
		.waddr_x(waddr_x), .tnew_x(tnew_x)
	);

	mem_stage u_mem_stage (
		.clk(clk), .arst_n(arst_n), .fwd_st(fwd_st),
		.alu_res_m(alu_res_m), .store_data_m(store_data_m), .pc8_m(pc8_m),
		.waddr_m(waddr_m), .wb_sel_m(wb_sel_m), .mem_type_m(mem_type_m),
		.data_rdata(m_data_rdata), .data_addr(m_data_addr), .data_wdata(m_data_wdata),
		.byteen(m_data_byteen), .inst_addr_m(m_inst_addr), .res_m(res_m),
		.we_w(w_grf_we), .waddr_w(w_grf_addr), .res_w(w_grf_wdata), .pc_w(w_inst_addr)
	);

	hazard_unit u_hazard_unit (
		.rs_d(rs_d), .rt_d(rt_d), .tuse_rs(tuse_rs), .tuse_rt(tuse_rt),
		.waddr_x(waddr_x), .tnew_x(tnew_x), .rs_e(rs_e), .rt_e(rt_e),
		.waddr_m(waddr_m), .tnew_m(tnew_m), .rt_m(rt_m),
		.we_w(w_grf_we), .waddr_w(w_grf_addr),
		.stall(stall), .flush(flush),
		.fwd_cmp_a(fwd_cmp_a), .fwd_cmp_b(fwd_cmp_b),
		.fwd_alu_a(fwd_alu_a), .fwd_alu_b(fwd_alu_b), .fwd_st(fwd_st)
	);

endmodule

// ==== dv/mips_tb.sv ====
`timescale 1ns/1ps

module mips_tb;
	import isa_pkg::*;

	localparam logic [31:0] RESET_PC = 32'h0000_3000;
	localparam int PROG_LEN = 64;
	localparam int WATCHDOG_NS = 4 * PROG_LEN * 4 + 50 * 4; // worst case stalls plus drain

	logic        clk;
	logic        arst_n;
	logic [31:0] i_inst_rdata;
	logic [31:0] m_data_rdata;
	logic [31:0] i_inst_addr;
	logic [31:0] m_data_addr;
	logic [31:0] m_data_wdata;
	logic [3:0]  m_data_byteen;
	logic [31:0] m_inst_addr;
	logic        w_grf_we;
	logic [4:0]  w_grf_addr;
	logic [31:0] w_grf_wdata;
	logic [31:0] w_inst_addr;

	logic [31:0] imem [128];
	logic [31:0] dmem [64];
	logic [31:0] regs [32]; // model register file
	logic [31:0] mdm [64];  // model data memory
	bit          is_tgt [128];
	int          p;
	int          since_rst;
	bit          started;
	int          chk [1:5];
	int          err [1:5];
	int          total_chk;
	int          total_err;

	// expected writebacks and stores in program order
	logic [4:0]  exp_reg [$];
	logic [31:0] exp_val [$];
	logic [31:0] exp_pc [$];
	int          exp_kind [$]; // 0 alu, 1 load, 2 link
	logic [31:0] st_addr [$];
	logic [3:0]  st_be [$];
	logic [31:0] st_data [$];
	logic [31:0] st_pc [$];

	mips #(.RESET_PC(RESET_PC)) UUT (
		.clk(clk), .arst_n(arst_n), .i_inst_rdata(i_inst_rdata), .m_data_rdata(m_data_rdata),
		.i_inst_addr(i_inst_addr), .m_data_addr(m_data_addr), .m_data_wdata(m_data_wdata),
		.m_data_byteen(m_data_byteen), .m_inst_addr(m_inst_addr), .w_grf_we(w_grf_we),
		.w_grf_addr(w_grf_addr), .w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr)
	);

	// nops outside the program window
	assign i_inst_rdata = (i_inst_addr - RESET_PC < 32'd512) ?
		imem[(i_inst_addr - RESET_PC) >> 2] : 32'd0;
	assign m_data_rdata = dmem[m_data_addr[7:2]];

	always @(posedge clk) begin
		for (int k = 0; k < 4; k++)
			if (m_data_byteen[k])
				dmem[m_data_addr[7:2]][8 * k +: 8] <= m_data_wdata[8 * k +: 8];
	end

	always #2 clk = ~clk;

	function automatic logic [31:0] fill_word(input int i);
		return {8'(i) ^ 8'hc3, 8'(i * 7), ~8'(i), 8'(i)};
	endfunction

	function automatic logic [31:0] lane_mask(input logic [3:0] be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	function automatic logic [31:0] r_format(input logic [4:0] rs, rt, rd, input funct_e fn);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_format(input opcode_e op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [4:0] pick_src();
		int r;
		r = $urandom_range(0, 7);
		return (r == 7) ? 5'd31 : 5'(r);
	endfunction

	function automatic logic [4:0] pick_dst();
		return 5'($urandom_range(0, 6)); // $7 is kept for jr targets
	endfunction

	function automatic string behavior_name(input int b);
		case (b)
			1: return "writeback order";
			2: return "forwarded and loaded values";
			3: return "data stores";
			4: return "branches, jumps and links";
			default: return "reset and register 0";
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[p] = w;
		p = p + 1;
	endtask

	task automatic emit_plain();
		int k;
		k = $urandom_range(0, 6);
		case (k)
			0: emit(r_format(pick_src(), pick_src(), pick_dst(), F_ADDU));
			1: emit(r_format(pick_src(), pick_src(), pick_dst(), F_SUBU));
			2: emit(i_format(OP_ORI, pick_src(), pick_dst(), 16'($urandom)));
			3: emit(i_format(OP_LUI, 5'd0, pick_dst(), 16'($urandom)));
			4: emit(i_format(OP_LW, 5'd0, pick_dst(), 16'(4 * $urandom_range(0, 15))));
			5: emit(i_format(OP_SW, 5'd0, pick_src(), 16'(4 * $urandom_range(0, 15))));
			default: emit(i_format(OP_SB, 5'd0, pick_src(), 16'($urandom_range(0, 63))));
		endcase
	endtask

	// forward-only targets, delay slots never hold a control instruction
	task automatic build_program();
		int         kind;
		int         tgt;
		logic [4:0] rs;
		p = 0;
		for (int r = 1; r <= 7; r++)
			emit(i_format(OP_ORI, 5'd0, (r == 7) ? 5'd31 : 5'(r), 16'($urandom)));
		while (p < PROG_LEN) begin
			kind = $urandom_range(0, 9);
			if (p >= PROG_LEN - 8 || kind < 7) begin
				emit_plain();
			end else if (kind == 9 && !is_tgt[p + 1]) begin
				tgt = p + 3 + $urandom_range(0, 3);
				is_tgt[tgt] = 1'b1;
				emit(i_format(OP_ORI, 5'd0, 5'd7, 16'(RESET_PC + 4 * tgt)));
				emit(r_format(5'd7, 5'd0, 5'd0, F_JR));
				emit_plain();
			end else if (kind == 8) begin
				tgt = p + 2 + $urandom_range(0, 3);
				is_tgt[tgt] = 1'b1;
				emit({OP_JAL, 26'((RESET_PC + 4 * tgt) >> 2)});
				emit_plain();
			end else begin
				rs = pick_src();
				tgt = $urandom_range(1, 4);
				is_tgt[p + 1 + tgt] = 1'b1;
				emit(i_format(OP_BEQ, rs, ($urandom_range(0, 1) == 1) ? rs : pick_src(),
					16'(tgt)));
				emit_plain();
			end
		end
	endtask

	task automatic record_write(input logic [4:0] rd, input logic [31:0] val,
		input logic [31:0] pc, input int kind);
		if (rd != 5'd0) begin
			regs[rd] = val;
			exp_reg.push_back(rd);
			exp_val.push_back(val);
			exp_pc.push_back(pc);
			exp_kind.push_back(kind);
		end
	endtask

	task automatic push_store(input logic [31:0] addr, input logic [3:0] be,
		input logic [31:0] data, input logic [31:0] pc);
		st_addr.push_back(addr);
		st_be.push_back(be);
		st_data.push_back(data);
		st_pc.push_back(pc);
	endtask

	task automatic run_model();
		logic [31:0] pc, npc, nnpc, w, a, b, sx, addr;
		int          lane;
		int          steps;
		for (int r = 0; r < 32; r++)
			regs[r] = 32'd0;
		pc    = RESET_PC;
		npc   = RESET_PC + 32'd4;
		steps = 0;
		while (pc != RESET_PC + 4 * PROG_LEN && steps < 2 * PROG_LEN) begin
			w    = imem[(pc - RESET_PC) >> 2];
			a    = regs[w[25:21]];
			b    = regs[w[20:16]];
			sx   = {{16{w[15]}}, w[15:0]};
			addr = a + sx;
			lane = addr[1:0];
			nnpc = npc + 32'd4; // npc is the delay slot
			case (w[31:26])
				OP_SPECIAL: begin
					if (w[5:0] == F_ADDU)
						record_write(w[15:11], a + b, pc, 0);
					else if (w[5:0] == F_SUBU)
						record_write(w[15:11], a - b, pc, 0);
					else if (w[5:0] == F_JR)
						nnpc = a;
				end
				OP_ORI: record_write(w[20:16], a | {16'd0, w[15:0]}, pc, 0);
				OP_LUI: record_write(w[20:16], {w[15:0], 16'd0}, pc, 0);
				OP_LW:  record_write(w[20:16], mdm[addr[7:2]], pc, 1);
				OP_SW: begin
					mdm[addr[7:2]] = b;
					push_store(addr, 4'hf, b, pc);
				end
				OP_SB: begin
					mdm[addr[7:2]][8 * lane +: 8] = b[7:0];
					push_store(addr, 4'b0001 << lane, {24'd0, b[7:0]} << (8 * lane),
						pc);
				end
				OP_BEQ: begin
					if (a == b)
						nnpc = npc + {sx[29:0], 2'b00};
				end
				OP_JAL: begin
					record_write(5'd31, pc + 32'd8, pc, 2);
					nnpc = {pc[31:28], w[25:0], 2'b00};
				end
				default: ;
			endcase
			pc    = npc;
			npc   = nnpc;
			steps = steps + 1;
		end
	endtask

	task automatic note_failure(input int b, input string msg);
		err[b]++;
		$display("%s at %0t", msg, $time);
	endtask

	task automatic compare_hex(input int b, input string name, input logic [31:0] got,
		input logic [31:0] expected);
		chk[b]++;
		assert (got === expected) else begin
			err[b]++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic check_writeback();
		chk[5]++;
		assert (w_grf_addr != 5'd0) else note_failure(5, "register 0 reported as written");
		chk[1]++;
		assert (exp_reg.size() != 0)
			else note_failure(1, "register write seen after the last expected writeback");
		if (exp_reg.size() != 0) begin
			compare_hex(1, "w_grf_addr", w_grf_addr, exp_reg[0]);
			compare_hex((exp_kind[0] == 2) ? 4 : 2, "w_grf_wdata", w_grf_wdata, exp_val[0]);
			compare_hex(4, "w_inst_addr", w_inst_addr, exp_pc[0]);
			void'(exp_reg.pop_front());
			void'(exp_val.pop_front());
			void'(exp_pc.pop_front());
			void'(exp_kind.pop_front());
		end
	endtask

	task automatic check_store();
		chk[3]++;
		assert (st_addr.size() != 0)
			else note_failure(3, "store seen after the last expected store");
		if (st_addr.size() != 0) begin
			compare_hex(3, "m_data_addr", m_data_addr, st_addr[0]);
			compare_hex(3, "m_data_byteen", m_data_byteen, st_be[0]);
			compare_hex(3, "m_data_wdata", m_data_wdata & lane_mask(st_be[0]), st_data[0]);
			compare_hex(3, "m_inst_addr", m_inst_addr, st_pc[0]);
			void'(st_addr.pop_front());
			void'(st_be.pop_front());
			void'(st_data.pop_front());
			void'(st_pc.pop_front());
		end
	endtask

	// outputs sampled at the rising edge, before the DUT updates them
	always @(posedge clk) begin
		if (started && (!arst_n || since_rst < 4)) begin
			chk[5]++;
			assert (w_grf_we === 1'b0 && m_data_byteen === 4'd0)
				else note_failure(5, "write strobe active before the first instruction retired");
		end
		if (arst_n)
			since_rst++;
		if (w_grf_we === 1'b1)
			check_writeback();
		if (arst_n && m_data_byteen !== 4'd0)
			check_store();
		started = 1'b1;
	end

	initial begin
		clk    = 1'b0;
		arst_n = 1'b0;
		void'($urandom(32'hbb9b5b84));
		for (int i = 0; i < 128; i++)
			imem[i] = 32'd0;
		for (int i = 0; i < 64; i++) begin
			dmem[i] = fill_word(i);
			mdm[i]  = fill_word(i);
		end
		build_program();
		run_model();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		while (exp_reg.size() != 0 || st_addr.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk); // catch stray writes
		for (int b = 1; b <= 5; b++) begin
			if (chk[b] == 0)
				note_failure(b, "no check was reached for this behavior");
			$display("%-28s %0d checks, %0d errors", behavior_name(b), chk[b], err[b]);
			total_chk += chk[b];
			total_err += err[b];
		end
		$display("total: %0d checks, %0d errors", total_chk, total_err);
		if (total_err == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired with %0d writebacks and %0d stores still pending",
			exp_reg.size(), st_addr.size());
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== mips.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/mem_stage.sv
hw/hazard_unit.sv
hw/mips.sv
dv/mips_tb.sv
